/* src/vcoal_config.svh */
/*
 * coalescer build parameters
 * word size, lane count and cache block geometry
 */

`ifndef VCOAL_CONFIG_SVH
`define VCOAL_CONFIG_SVH

// data and address width in bits
`define VC_WORD_SIZE 32
// lane count, the lane state enum names exactly four lanes
`define VC_NUM_LANES 4
// cache block size in words, any power of two
`define VC_BLOCK_WORDS 2
// word offset bits within a block, at least one
`define VC_BLOCK_BITS ($clog2(`VC_BLOCK_WORDS) + (`VC_BLOCK_WORDS == 1))
// lowest address bit of the block tag
`define VC_TAG_LSB (`VC_BLOCK_BITS + 2)

`endif

/* src/vcoal_pkg.sv */
/*
 * shared coalescer types
 * word and lane vectors, lane state, element width and load opcodes
 */

`include "vcoal_config.svh"

package vcoal_pkg;

    typedef logic [`VC_WORD_SIZE-1:0] word_t;

    typedef logic [$clog2(`VC_NUM_LANES)-1:0] lane_idx_t;

    // one bit per lane, for masks and cover sets
    typedef logic [`VC_NUM_LANES-1:0] lane_mask_t;

    // lane 0 in the lowest word
    typedef word_t [`VC_NUM_LANES-1:0] lane_words_t;

    typedef word_t [`VC_BLOCK_WORDS-1:0] block_data_t;

    // lane currently being issued
    typedef enum logic [1:0] {LANE0, LANE1, LANE2, LANE3} lane_state_t;

    // element width of the vector memory op
    typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_t;

    // load opcode handed to the load/store controller
    typedef enum logic [1:0] {LD_B, LD_H, LD_W} load_type_t;

endpackage

/* src/vcoal_lane_addr_gen.sv */
/*
 * per-lane address generation
 * indexed or strided lane addresses, with the strided
 * addresses carried from one micro-op to the next
 */

`timescale 1ns/100ps

`include "vcoal_config.svh"

module vcoal_lane_addr_gen (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  flush,
    input  logic                  vindexed,
    input  logic                  vuop_first,
    input  vcoal_pkg::word_t      base,
    input  vcoal_pkg::word_t      stride,
    input  vcoal_pkg::lane_words_t vlane_addr,
    input  logic                  uop_done,
    output vcoal_pkg::lane_words_t lane_addr
);

    import vcoal_pkg::*;

    lane_words_t first_addr;
    lane_words_t strided_q;
    lane_words_t strided_cur;
    lane_words_t strided_next;

    // first micro-op starts from base
    always_comb begin
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            first_addr[i] = base + stride * word_t'(i);
        end
    end

    assign strided_cur = vuop_first ? first_addr : strided_q;

    // continue the stride past the last lane of this micro-op
    always_comb begin
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            strided_next[i] = strided_cur[`VC_NUM_LANES-1] + stride * word_t'(i + 1);
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            strided_q <= '0;
        end else if (flush) begin
            strided_q <= '0;
        end else if (uop_done) begin
            strided_q <= strided_next;
        end
    end

    // lanes supply their own addresses in indexed mode
    assign lane_addr = vindexed ? vlane_addr : strided_cur;

endmodule

/* src/vcoal_block_match.sv */
/*
 * block tag match
 * compares later lanes with the current lane and forms
 * the set of lanes covered by one access
 */

`timescale 1ns/100ps

`include "vcoal_config.svh"

module vcoal_block_match (
    input  vcoal_pkg::lane_state_t cur_state,
    input  vcoal_pkg::lane_words_t lane_addr,
    input  logic                   vindexed,
    input  logic                   vmemdwen,
    output vcoal_pkg::lane_mask_t  cover_set
);

    import vcoal_pkg::*;

    logic [`VC_WORD_SIZE-1:`VC_TAG_LSB] lane_tag [`VC_NUM_LANES];
    lane_idx_t cur_idx;
    logic      merge_ok;

    assign cur_idx = lane_idx_t'(cur_state);

    always_comb begin
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            lane_tag[i] = lane_addr[i][`VC_WORD_SIZE-1:`VC_TAG_LSB];
        end
    end

    // strided stores go out one lane at a time
    assign merge_ok = vindexed || !vmemdwen;

    always_comb begin
        cover_set = '0;
        cover_set[cur_idx] = 1'b1;
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            // only lanes after the current one can join its group
            if (merge_ok && (i > int'(cur_idx))) begin
                cover_set[i] = (lane_tag[i] == lane_tag[cur_idx]);
            end
        end
    end

endmodule

/* src/vcoal_lane_sequencer.sv */
/*
 * lane sequencer
 * lane FSM that issues one group per accepted access, skips
 * covered and masked lanes and drives the stall to the lanes
 */

`timescale 1ns/100ps

`include "vcoal_config.svh"

module vcoal_lane_sequencer (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   flush,
    input  logic                   vmemdren,
    input  logic                   vmemdwen,
    input  logic                   lsc_ready,
    input  vcoal_pkg::lane_mask_t  vlane_mask,
    input  vcoal_pkg::lane_mask_t  cover_set,
    input  vcoal_pkg::lane_words_t lane_addr,
    output vcoal_pkg::lane_state_t cur_state,
    output vcoal_pkg::lane_idx_t   vcurr_lane,
    output vcoal_pkg::word_t       vaddr_lsc,
    output vcoal_pkg::lane_mask_t  ven_lanes,
    output logic                   vmemdren_lsc,
    output logic                   vmemdwen_lsc,
    output logic                   last_lane,
    output logic                   coalescer_stall,
    output logic                   uop_done
);

    import vcoal_pkg::*;

    lane_state_t next_state;
    lane_state_t skip_state;
    lane_idx_t   cur_idx;
    logic        active;
    logic        cur_mask;
    logic        grp_done;
    logic        final_grp;

    assign cur_idx  = lane_idx_t'(cur_state);
    assign active   = vmemdren || vmemdwen;
    assign cur_mask = vlane_mask[cur_idx];

    // a masked lane needs no acceptance from the LSC
    assign grp_done = active && (!cur_mask || lsc_ready);

    // lowest later lane outside the current group
    always_comb begin
        skip_state = LANE0;
        final_grp  = 1'b1;
        for (int i = `VC_NUM_LANES - 1; i >= 0; i--) begin
            if ((i > int'(cur_idx)) && !cover_set[i]) begin
                skip_state = lane_state_t'(lane_idx_t'(i));
                final_grp  = 1'b0;
            end
        end
    end

    assign next_state = grp_done ? skip_state : cur_state;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cur_state <= LANE0;
        end else if (flush) begin
            cur_state <= LANE0;
        end else begin
            cur_state <= next_state;
        end
    end

    assign vcurr_lane = cur_idx;
    assign vaddr_lsc  = lane_addr[cur_idx];
    assign ven_lanes  = active ? cover_set : '0;

    assign vmemdren_lsc = vmemdren && cur_mask;
    assign vmemdwen_lsc = vmemdwen && cur_mask;

    // group reaches the top lane
    assign last_lane = final_grp;

    assign uop_done        = grp_done && final_grp;
    assign coalescer_stall = active && !uop_done;

    // group built by the tag match always holds the issuing lane
    assert property (@(posedge CLK) disable iff (!nRST) cover_set[cur_idx])
        else $error("cover is missing the current lane");

    assert property (@(posedge CLK) disable iff (!nRST)
        (active && cur_mask && !lsc_ready && !flush) |=> (cur_state == $past(cur_state)))
        else $error("lane state moved under back-pressure");

    assert property (@(posedge CLK) disable iff (!nRST) !(vmemdren_lsc && vmemdwen_lsc))
        else $error("read and write issued together");

endmodule

/* src/vcoal_access_format.sv */
/*
 * access formatting
 * current lane store word, block-wide store data and
 * load type decode from the element width
 */

`timescale 1ns/100ps

`include "vcoal_config.svh"

module vcoal_access_format (
    input  vcoal_pkg::lane_state_t cur_state,
    input  vcoal_pkg::lane_mask_t  cover_set,
    input  vcoal_pkg::lane_words_t lane_addr,
    input  vcoal_pkg::lane_words_t vlane_store_data,
    input  vcoal_pkg::sew_t        veew,
    output vcoal_pkg::word_t       vdata_store_lsc,
    output vcoal_pkg::block_data_t vdata_store_wide_lsc,
    output vcoal_pkg::load_type_t  vload_type
);

    import vcoal_pkg::*;

    logic [`VC_BLOCK_BITS-1:0] lane_slot [`VC_NUM_LANES];

    assign vdata_store_lsc = vlane_store_data[lane_idx_t'(cur_state)];

    // word slot of each lane inside its block
    always_comb begin
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            lane_slot[i] = lane_addr[i][`VC_BLOCK_BITS+1:2];
        end
    end

    always_comb begin
        vdata_store_wide_lsc = '0;
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            if (cover_set[i]) begin
                vdata_store_wide_lsc[lane_slot[i]] = vlane_store_data[i];
            end
        end
    end

    always_comb begin
        case (veew)
            SEW8:    vload_type = LD_B;
            SEW16:   vload_type = LD_H;
            SEW32:   vload_type = LD_W;
            default: vload_type = LD_W;
        endcase
    end

    // two covered lanes in different words must not share a slot
    always_comb begin
        for (int i = 0; i < `VC_NUM_LANES; i++) begin
            for (int j = i + 1; j < `VC_NUM_LANES; j++) begin
                if (cover_set[i] && cover_set[j] && (lane_addr[i][`VC_WORD_SIZE-1:2] !=
                                                     lane_addr[j][`VC_WORD_SIZE-1:2])) begin
                    assert (lane_slot[i] != lane_slot[j])
                        else $error("covered lanes %0d and %0d share a block slot", i, j);
                end
            end
        end
    end

endmodule

/* src/vcoal_top.sv */
/*
 * vector memory access coalescer
 * address generation, block match, lane FSM and access formatting
 */

`timescale 1ns/100ps

module vcoal_top (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   flush,
    input  logic                   vmemdren,
    input  logic                   vmemdwen,
    input  logic                   vindexed,
    input  logic                   vuop_first,
    input  vcoal_pkg::word_t       base,
    input  vcoal_pkg::word_t       stride,
    input  vcoal_pkg::lane_words_t vlane_addr,
    input  vcoal_pkg::lane_mask_t  vlane_mask,
    input  vcoal_pkg::lane_words_t vlane_store_data,
    input  vcoal_pkg::sew_t        veew,
    input  logic                   lsc_ready,
    output vcoal_pkg::word_t       vaddr_lsc,
    output vcoal_pkg::lane_words_t vaddr_wide_lsc,
    output vcoal_pkg::lane_mask_t  ven_lanes,
    output vcoal_pkg::lane_idx_t   vcurr_lane,
    output logic                   vmemdren_lsc,
    output logic                   vmemdwen_lsc,
    output vcoal_pkg::word_t       vdata_store_lsc,
    output vcoal_pkg::block_data_t vdata_store_wide_lsc,
    output vcoal_pkg::load_type_t  vload_type,
    output logic                   last_lane,
    output logic                   coalescer_stall
);

    import vcoal_pkg::*;

    lane_words_t lane_addr;
    lane_mask_t  cover_set;
    lane_state_t cur_state;
    logic        uop_done;

    // LSC sees every lane address for wide accesses
    assign vaddr_wide_lsc = lane_addr;

    vcoal_lane_addr_gen u_lane_addr_gen (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .vindexed   (vindexed),
        .vuop_first (vuop_first),
        .base       (base),
        .stride     (stride),
        .vlane_addr (vlane_addr),
        .uop_done   (uop_done),
        .lane_addr  (lane_addr)
    );

    vcoal_block_match u_block_match (
        .cur_state (cur_state),
        .lane_addr (lane_addr),
        .vindexed  (vindexed),
        .vmemdwen  (vmemdwen),
        .cover_set (cover_set)
    );

    vcoal_lane_sequencer u_lane_sequencer (
        .CLK             (CLK),
        .nRST            (nRST),
        .flush           (flush),
        .vmemdren        (vmemdren),
        .vmemdwen        (vmemdwen),
        .lsc_ready       (lsc_ready),
        .vlane_mask      (vlane_mask),
        .cover_set       (cover_set),
        .lane_addr       (lane_addr),
        .cur_state       (cur_state),
        .vcurr_lane      (vcurr_lane),
        .vaddr_lsc       (vaddr_lsc),
        .ven_lanes       (ven_lanes),
        .vmemdren_lsc    (vmemdren_lsc),
        .vmemdwen_lsc    (vmemdwen_lsc),
        .last_lane       (last_lane),
        .coalescer_stall (coalescer_stall),
        .uop_done        (uop_done)
    );

    vcoal_access_format u_access_format (
        .cur_state            (cur_state),
        .cover_set            (cover_set),
        .lane_addr            (lane_addr),
        .vlane_store_data     (vlane_store_data),
        .veew                 (veew),
        .vdata_store_lsc      (vdata_store_lsc),
        .vdata_store_wide_lsc (vdata_store_wide_lsc),
        .vload_type           (vload_type)
    );

endmodule

/* dv/vcoal_tb.sv */
/*
 * directed testbench for the vector memory coalescer
 * clock, reset, value check and one task per behavior
 */

`timescale 1ns/100ps

module vcoal_tb;

    import vcoal_pkg::*;

    localparam int CLK_HALF       = 20;
    localparam int ACCEPT_TIMEOUT = 64;

    logic        CLK;
    logic        nRST;
    logic        flush;
    logic        vmemdren;
    logic        vmemdwen;
    logic        vindexed;
    logic        vuop_first;
    word_t       base;
    word_t       stride;
    lane_words_t vlane_addr;
    lane_mask_t  vlane_mask;
    lane_words_t vlane_store_data;
    sew_t        veew;
    logic        lsc_ready;
    word_t       vaddr_lsc;
    lane_words_t vaddr_wide_lsc;
    lane_mask_t  ven_lanes;
    lane_idx_t   vcurr_lane;
    logic        vmemdren_lsc;
    logic        vmemdwen_lsc;
    word_t       vdata_store_lsc;
    block_data_t vdata_store_wide_lsc;
    load_type_t  vload_type;
    logic        last_lane;
    logic        coalescer_stall;
    int          seed;

    vcoal_top u_vcoal_top (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_HALF) CLK = ~CLK;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("error: %s is %0h, expected %0h", name, actual, expected));
        end
    endtask

    // outputs are sampled a quarter period after the falling edge
    task automatic settle();
        #(CLK_HALF / 2);
    endtask

    task automatic next_cycle();
        @(negedge CLK);
    endtask

    task automatic apply_reset();
        nRST = 1'b0;
        repeat (10) next_cycle();
        nRST = 1'b1;
    endtask

    // 8-byte blocks, so address bit 2 picks the word slot
    function automatic block_data_t single_slot_block(input word_t addr, input word_t data);
        block_data_t blk;
        blk = '0;
        blk[addr[2]] = data;
        return blk;
    endfunction

    // hold one group until it completes, checking it on every cycle
    task automatic issue_group(input lane_idx_t lane, input word_t addr, input lane_mask_t en,
                               input logic last, input logic rand_ready,
                               input logic store_chk, input word_t store_word,
                               input block_data_t store_wide);
        int    cycles;
        logic  done;
        logic  lane_on;
        word_t rnd;
        cycles  = 0;
        done    = 1'b0;
        lane_on = vlane_mask[lane];
        while (!done) begin
            rnd = $random(seed);
            // first cycle is always refused under random back-pressure
            lsc_ready = rand_ready ? ((cycles > 0) && rnd[0]) : 1'b1;
            settle();
            done = !lane_on || lsc_ready;
            check_value("vcurr_lane", 128'(vcurr_lane), 128'(lane));
            check_value("vaddr_lsc", 128'(vaddr_lsc), 128'(addr));
            check_value("ven_lanes", 128'(ven_lanes), 128'(en));
            check_value("last_lane", 128'(last_lane), 128'(last));
            check_value("vmemdren_lsc", 128'(vmemdren_lsc), 128'(vmemdren && lane_on));
            check_value("vmemdwen_lsc", 128'(vmemdwen_lsc), 128'(vmemdwen && lane_on));
            check_value("coalescer_stall", 128'(coalescer_stall), 128'(!(done && last)));
            if (store_chk) begin
                check_value("vdata_store_lsc", 128'(vdata_store_lsc), 128'(store_word));
                check_value("vdata_store_wide_lsc", 128'(vdata_store_wide_lsc),
                            128'(store_wide));
            end
            next_cycle();
            cycles++;
            if (!done && (cycles >= ACCEPT_TIMEOUT)) begin
                stop_run($sformatf("timeout: lane %0d was never accepted", lane));
            end
        end
    endtask

    task automatic go_idle();
        vmemdren   = 1'b0;
        vmemdwen   = 1'b0;
        vindexed   = 1'b0;
        vuop_first = 1'b1;
        lsc_ready  = 1'b0;
        flush      = 1'b0;
        settle();
        check_value("coalescer_stall", 128'(coalescer_stall), 128'(1'b0));
        check_value("vmemdren_lsc", 128'(vmemdren_lsc), 128'(1'b0));
        check_value("vmemdwen_lsc", 128'(vmemdwen_lsc), 128'(1'b0));
        check_value("ven_lanes", 128'(ven_lanes), 128'(4'b0000));
        next_cycle();
    endtask

    task automatic reset_and_idle();
        sew_t       widths [3];
        load_type_t types  [3];
        widths = '{SEW8, SEW16, SEW32};
        types  = '{LD_B, LD_H, LD_W};
        go_idle();
        for (int i = 0; i < 3; i++) begin
            veew = widths[i];
            settle();
            check_value("vload_type", 128'(vload_type), 128'(types[i]));
            next_cycle();
        end
    endtask

    task automatic strided_load_coalesce();
        word_t rnd;
        rnd        = $random(seed);
        base       = {rnd[31:3], 3'b000};
        stride     = 32'd4;
        vlane_mask = 4'b1111;
        vmemdren   = 1'b1;
        // lanes 0 and 1 fill the first block, lanes 2 and 3 the next
        issue_group(2'd0, base, 4'b0011, 1'b0, 1'b0, 1'b0, '0, '0);
        issue_group(2'd2, base + 32'd8, 4'b1100, 1'b1, 1'b0, 1'b0, '0, '0);
        go_idle();
    endtask

    task automatic strided_store_continue();
        word_t rnd;
        word_t start;
        word_t addr;
        rnd    = $random(seed);
        base   = {rnd[31:2], 2'b00};
        stride = 32'd4;
        for (int i = 0; i < 4; i++) begin
            vlane_store_data[i] = $random(seed);
        end
        vlane_mask = 4'b1111;
        vmemdwen   = 1'b1;
        for (int uop = 0; uop < 2; uop++) begin
            // second micro-op carries on past lane 3 of the first
            vuop_first = (uop == 0);
            start      = base + stride * word_t'(4 * uop);
            for (int k = 0; k < 4; k++) begin
                addr = start + stride * word_t'(k);
                issue_group(lane_idx_t'(k), addr, lane_mask_t'(1 << k), k == 3, 1'b0, 1'b1,
                            vlane_store_data[k], single_slot_block(addr, vlane_store_data[k]));
            end
        end
        go_idle();
    endtask

    task automatic indexed_store_pairs();
        word_t       rnd;
        word_t       blk_a;
        word_t       blk_b;
        block_data_t wide;
        rnd   = $random(seed);
        blk_a = {rnd[31:3], 3'b000};
        blk_b = blk_a ^ 32'h0000_0040;
        vlane_addr[0] = blk_a + 32'd4;
        vlane_addr[1] = blk_b;
        vlane_addr[2] = blk_a;
        vlane_addr[3] = blk_b + 32'd4;
        for (int i = 0; i < 4; i++) begin
            vlane_store_data[i] = $random(seed);
        end
        vindexed   = 1'b1;
        vmemdwen   = 1'b1;
        vlane_mask = 4'b1111;
        // lane 0 sits in slot 1 and lane 2 in slot 0 of block a
        wide[1] = vlane_store_data[0];
        wide[0] = vlane_store_data[2];
        issue_group(2'd0, vlane_addr[0], 4'b0101, 1'b0, 1'b0, 1'b1, vlane_store_data[0], wide);
        check_value("vaddr_wide_lsc", 128'(vaddr_wide_lsc), 128'(vlane_addr));
        wide[0] = vlane_store_data[1];
        wide[1] = vlane_store_data[3];
        issue_group(2'd1, vlane_addr[1], 4'b1010, 1'b0, 1'b0, 1'b1, vlane_store_data[1], wide);
        // lane 2 lies outside the lane 1 group so the walk goes on from there
        issue_group(2'd2, vlane_addr[2], 4'b0100, 1'b0, 1'b0, 1'b1, vlane_store_data[2],
                    single_slot_block(vlane_addr[2], vlane_store_data[2]));
        issue_group(2'd3, vlane_addr[3], 4'b1000, 1'b1, 1'b0, 1'b1, vlane_store_data[3],
                    single_slot_block(vlane_addr[3], vlane_store_data[3]));
        go_idle();
    endtask

    task automatic mask_and_backpressure();
        word_t rnd;
        rnd        = $random(seed);
        base       = {rnd[31:3], 3'b000};
        stride     = 32'd64;
        vlane_mask = 4'b1011;
        vmemdren   = 1'b1;
        // every lane in a block of its own and lane 2 masked off
        issue_group(2'd0, base, 4'b0001, 1'b0, 1'b1, 1'b0, '0, '0);
        issue_group(2'd1, base + 32'd64, 4'b0010, 1'b0, 1'b1, 1'b0, '0, '0);
        issue_group(2'd2, base + 32'd128, 4'b0100, 1'b0, 1'b1, 1'b0, '0, '0);
        // lane 3 refused, then flushed back to lane 0
        lsc_ready = 1'b0;
        flush     = 1'b1;
        settle();
        check_value("vcurr_lane", 128'(vcurr_lane), 128'(2'd3));
        check_value("coalescer_stall", 128'(coalescer_stall), 128'(1'b1));
        next_cycle();
        flush = 1'b0;
        settle();
        check_value("vcurr_lane", 128'(vcurr_lane), 128'(2'd0));
        check_value("vaddr_lsc", 128'(vaddr_lsc), 128'(base));
        next_cycle();
        go_idle();
    endtask

    initial begin
        seed             = 32'h2fad_6b73;
        nRST             = 1'b0;
        flush            = 1'b0;
        vmemdren         = 1'b0;
        vmemdwen         = 1'b0;
        vindexed         = 1'b0;
        vuop_first       = 1'b1;
        base             = '0;
        stride           = '0;
        vlane_addr       = '0;
        vlane_mask       = '0;
        vlane_store_data = '0;
        veew             = SEW32;
        lsc_ready        = 1'b0;
        apply_reset();
        reset_and_idle();
        strided_load_coalesce();
        strided_store_continue();
        indexed_store_pairs();
        mask_and_backpressure();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/vcoal_pkg.sv
src/vcoal_lane_addr_gen.sv
src/vcoal_block_match.sv
src/vcoal_lane_sequencer.sv
src/vcoal_access_format.sv
src/vcoal_top.sv
dv/vcoal_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the coalescer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module vcoal_tb -f sim.f -o vcoal_sim

# a failing run still prints its output before the search decides
out=$(./obj_dir/vcoal_sim) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
